/* src/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // Serial line timing.
  localparam int BAUD_DIV          = 434; // Clock cycles per bit.
  localparam int FRAME_BITS        = 11;  // Start, eight data, parity and stop.
  localparam int DATA_BITS         = 8;
  localparam int GAP_BITS          = 2;   // Idle bit times between write frames.
  localparam int RESP_TIMEOUT_BITS = 24;  // Bit times allowed for a read response.

  // Command word layout.
  localparam int DIR_BIT = 15; // High for a write.

  typedef logic [15:0] cmd_t;
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  addr_t;
  typedef logic [8:0]  baud_cnt_t;
  typedef logic [13:0] timer_t;

  // Terminal counts derived from the timing above.
  localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(BAUD_DIV - 1);
  localparam baud_cnt_t HALF_LAST = baud_cnt_t'(BAUD_DIV / 2 - 1);
  localparam timer_t    GAP_LAST  = timer_t'(GAP_BITS * BAUD_DIV - 1);
  localparam timer_t    RESP_LAST = timer_t'(RESP_TIMEOUT_BITS * BAUD_DIV - 1);

  typedef enum logic [2:0] {
    IDLE,
    SEND_HEADER,
    WAIT_HEADER,
    GAP,
    SEND_DATA,
    WAIT_DATA,
    WAIT_RESP
  } seq_state_t;

endpackage

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  tx_done,
  output logic  tx
);

  logic                  busy;
  baud_cnt_t             baud_cnt;
  logic [3:0]            bit_cnt;
  logic [FRAME_BITS-2:0] shift; // Bits still to go after the start bit.
  logic                  bit_end;
  logic                  load;

  assign load    = tx_start && !busy;
  assign bit_end = busy && (baud_cnt == BAUD_LAST);

  // Stop, even parity and data, sent from bit 0 upward.
  always_ff @(posedge clk) begin
    if (load) begin
      shift <= {1'b1, ^tx_byte, tx_byte};
    end else if (bit_end) begin
      shift <= {1'b1, shift[FRAME_BITS-2:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
      tx_done  <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (load) begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
        tx       <= 1'b0; // Start bit.
      end else if (bit_end) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'(FRAME_BITS - 1)) begin
          busy    <= 1'b0;
          tx_done <= 1'b1; // Stop bit has run its full time.
        end else begin
          tx      <= shift[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (busy) begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  output logic  rx_valid,
  output byte_t rx_byte,
  output logic  rx_bad
);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_last;
  logic       busy;
  baud_cnt_t  baud_cnt;
  logic [3:0] bit_cnt; // Zero is the start bit and FRAME_BITS-1 the stop bit.
  logic       parity;
  logic       sample;
  logic       fall;

  assign fall   = rx_last && !rx_sync;
  assign sample = busy && (bit_cnt != '0) && (baud_cnt == BAUD_LAST);

  // The line idles high, so the flops come out of reset high.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  // Data arrives least significant bit first.
  always_ff @(posedge clk) begin
    if (sample && (bit_cnt <= 4'(DATA_BITS))) begin
      rx_byte <= {rx_sync, rx_byte[7:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      parity   <= 1'b0;
      rx_valid <= 1'b0;
      rx_bad   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!busy) begin
        if (fall) begin
          busy     <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
          parity   <= 1'b0;
        end
      end else if (bit_cnt == '0) begin
        if (baud_cnt == HALF_LAST) begin
          baud_cnt <= '0;
          if (rx_sync) begin
            busy <= 1'b0; // A glitch, not a start bit.
          end else begin
            bit_cnt <= 4'd1;
          end
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end else if (sample) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'(FRAME_BITS - 1)) begin
          busy     <= 1'b0;
          rx_valid <= 1'b1;
          rx_bad   <= parity || !rx_sync;
        end else begin
          parity  <= parity ^ rx_sync; // Data plus parity bit sums to zero when good.
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/uart_cmd_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_seq
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  output logic  tx_start,
  output byte_t tx_byte,
  input  logic  tx_done,
  input  logic  rx_valid,
  input  byte_t rx_byte,
  input  logic  rx_bad,
  output byte_t read_data,
  output logic  read_rdy,
  output logic  read_err
);

  seq_state_t state;
  cmd_t       cmd_reg;
  timer_t     timer;
  addr_t      addr;
  byte_t      header;
  byte_t      wr_data;
  logic       is_write;
  logic       accept;
  logic       resp_ok;

  assign cmd_rdy  = (state == IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign is_write = cmd_reg[DIR_BIT];
  assign addr     = cmd_reg[14:8];
  assign wr_data  = cmd_reg[7:0];
  assign header   = {is_write, addr};

  // The transmitter samples tx_byte only in the cycle tx_start is high.
  assign tx_start = (state == SEND_HEADER) || (state == SEND_DATA);
  assign tx_byte  = (state == SEND_DATA) ? wr_data : header;

  assign resp_ok = (state == WAIT_RESP) && rx_valid && !rx_bad;

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_reg <= cmd_in;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_ok) begin
      read_data <= rx_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      timer    <= '0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            state <= SEND_HEADER;
          end
        end
        SEND_HEADER: begin
          state <= WAIT_HEADER;
        end
        WAIT_HEADER: begin
          if (tx_done) begin
            timer <= '0;
            state <= is_write ? GAP : WAIT_RESP;
          end
        end
        GAP: begin
          if (timer == GAP_LAST) begin
            state <= SEND_DATA;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        SEND_DATA: begin
          state <= WAIT_DATA;
        end
        WAIT_DATA: begin
          if (tx_done) begin
            state <= IDLE;
          end
        end
        WAIT_RESP: begin
          if (rx_valid) begin
            read_rdy <= !rx_bad;
            read_err <= rx_bad; // Parity or stop bit was wrong.
            state    <= IDLE;
          end else if (timer == RESP_LAST) begin
            read_err <= 1'b1; // Peer never answered.
            state    <= IDLE;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/uart_master.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_master
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  input  logic  rx,
  output logic  tx,
  output byte_t read_data,
  output logic  read_rdy,
  output logic  read_err
);

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_done;
  logic  rx_valid;
  byte_t rx_byte;
  logic  rx_bad;

  uart_cmd_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_bad    (rx_bad),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_bad   (rx_bad)
  );

endmodule

`default_nettype wire

/* verif/uart_peer.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_peer
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       tx,
  input  logic [1:0] resp_mode, // 0 answers, 1 flips the parity bit, 2 stays silent.
  output logic       rx,
  output logic       frame_vld,
  output byte_t      frame_byte,
  output logic       frame_ok
);

  byte_t regs [128];
  byte_t bits;
  addr_t wr_addr;
  logic  tx_last;
  logic  par_bit;
  logic  want_data;

  task automatic send_frame(input byte_t value, input logic flip);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, (^value) ^ flip, value, 1'b0};
    for (int i = 0; i < FRAME_BITS - 1; i++) begin
      rx = frame[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
    rx = frame[FRAME_BITS-1]; // Stop bit is the idle level, so tx is watched again from here.
  endtask

  initial begin
    rx         = 1'b1;
    frame_vld  = 1'b0;
    frame_byte = '0;
    frame_ok   = 1'b0;
    tx_last    = 1'b1;
    want_data  = 1'b0;
    wr_addr    = '0;
    for (int a = 0; a < 128; a++) begin
      regs[a] = '0;
    end
    forever begin
      @(negedge clk);
      frame_vld = 1'b0;
      if (tx_last && !tx) begin
        repeat (BAUD_DIV / 2) @(negedge clk); // Centre of the start bit.
        for (int i = 0; i < DATA_BITS; i++) begin
          repeat (BAUD_DIV) @(negedge clk);
          bits[i] = tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        par_bit = tx;
        repeat (BAUD_DIV) @(negedge clk);
        frame_byte = bits;
        frame_ok   = (par_bit == ^bits) && tx; // Even parity and a high stop bit.
        frame_vld  = 1'b1;
        if (want_data) begin
          regs[wr_addr] = bits;
          want_data     = 1'b0;
        end else if (bits[7]) begin
          wr_addr   = bits[6:0];
          want_data = 1'b1;
        end else if (resp_mode != 2'd2) begin
          @(negedge clk);
          frame_vld = 1'b0;
          repeat ((($urandom % 4) + 2) * BAUD_DIV) @(negedge clk);
          send_frame(regs[bits[6:0]], resp_mode == 2'd1);
        end
      end
      tx_last = tx;
    end
  end

endmodule

`default_nettype wire

/* verif/uart_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tb
  import uart_pkg::*;
();

  localparam int N_WRITES   = 10;
  localparam int N_READS    = 10;
  localparam int IDLE_LIMIT = (2 * FRAME_BITS + GAP_BITS + 4) * BAUD_DIV;
  localparam int READ_LIMIT = (FRAME_BITS + RESP_TIMEOUT_BITS + 4) * BAUD_DIV;
  localparam logic [1:0] MODE_NORMAL     = 2'd0;
  localparam logic [1:0] MODE_BAD_PARITY = 2'd1;
  localparam logic [1:0] MODE_SILENT     = 2'd2;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  byte_t      read_data;
  logic       read_rdy;
  logic       read_err;
  logic [1:0] resp_mode;
  logic       frame_vld;
  byte_t      frame_byte;
  logic       frame_ok;
  byte_t      shadow [128];  // Model of the peer's registers.
  logic [8:0] frame_q [$];   // Frames seen on tx, parity status on top.
  string      test_name;
  int         test_errors;
  int         total_errors;
  int         tests_run;
  int         tests_failed;
  int         n_rdy;
  int         n_err;
  byte_t      got;

  uart_master DUT (
    .clk(clk), .rst_n(rst_n), .cmd_in(cmd_in), .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy),
    .rx(rx), .tx(tx), .read_data(read_data), .read_rdy(read_rdy), .read_err(read_err)
  );

  uart_peer u_peer (
    .clk(clk), .tx(tx), .resp_mode(resp_mode), .rx(rx),
    .frame_vld(frame_vld), .frame_byte(frame_byte), .frame_ok(frame_ok)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (frame_vld) begin
      frame_q.push_back({frame_ok, frame_byte});
    end
  end

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%s: pass", test_name);
    end else begin
      $display("%s: %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic issue_cmd(input cmd_t cmd);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  // Counts result pulses until the sequencer is idle, then a few cycles more.
  task automatic wait_idle(input int limit);
    int cycles;
    n_rdy  = 0;
    n_err  = 0;
    cycles = 0;
    while (!cmd_rdy && cycles < limit) begin
      @(negedge clk);
      cycles++;
      n_rdy += int'(read_rdy);
      n_err += int'(read_err);
      if (read_rdy) begin
        got = read_data;
      end
    end
    assert (cmd_rdy) else begin
      $display("Timeout in %s: cmd_rdy did not come back high", test_name);
      test_errors++;
    end
    repeat (4) begin
      @(negedge clk);
      n_rdy += int'(read_rdy);
      n_err += int'(read_err);
    end
  endtask

  task automatic check_frame(input string what, input byte_t expected);
    logic [8:0] f;
    assert (frame_q.size() > 0) else begin
      $display("Missing %s frame on tx in %s", what, test_name);
      test_errors++;
    end
    if (frame_q.size() > 0) begin
      f = frame_q.pop_front();
      check_value({what, " byte"}, int'(expected), int'(f[7:0]));
      check_value({what, " parity and stop"}, 1, int'(f[8]));
    end
  endtask

  task automatic do_write(input addr_t addr, input byte_t data);
    issue_cmd({1'b1, addr, data});
    shadow[addr] = data;
    wait_idle(IDLE_LIMIT);
    check_frame("header", {1'b1, addr});
    check_frame("data", data);
    check_value("read pulses", 0, n_rdy + n_err);
    check_value("extra frames", 0, frame_q.size());
  endtask

  task automatic do_read(input addr_t addr, input logic [1:0] mode, input int exp_rdy);
    resp_mode = mode;
    got       = '0;
    issue_cmd({1'b0, addr, 8'h00});
    wait_idle(READ_LIMIT);
    check_frame("header", {1'b0, addr});
    check_value("read_rdy pulses", exp_rdy, n_rdy);
    check_value("read_err pulses", 1 - exp_rdy, n_err);
    if (exp_rdy == 1) begin
      check_value("read_data", int'(shadow[addr]), int'(got));
    end
    check_value("extra frames", 0, frame_q.size());
    resp_mode = MODE_NORMAL;
  endtask

  initial begin
    addr_t addr;
    byte_t data;
    void'($urandom(32'h7cb6_71b7));
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    resp_mode    = MODE_NORMAL;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int a = 0; a < 128; a++) begin
      shadow[a] = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset_state");
    check_value("tx", 1, int'(tx));
    check_value("cmd_rdy", 1, int'(cmd_rdy));
    check_value("read_rdy", 0, int'(read_rdy));
    check_value("read_err", 0, int'(read_err));
    end_test();

    begin_test("random_writes");
    for (int i = 0; i < N_WRITES; i++) begin
      do_write(addr_t'($urandom % 16), byte_t'($urandom));
    end
    end_test();

    begin_test("random_reads");
    for (int i = 0; i < N_READS; i++) begin
      do_read(addr_t'($urandom % 24), MODE_NORMAL, 1); // Some addresses were never written.
    end
    end_test();

    begin_test("bad_parity");
    do_read(addr_t'($urandom % 16), MODE_BAD_PARITY, 0);
    end_test();

    begin_test("silent_peer");
    do_read(addr_t'($urandom % 16), MODE_SILENT, 0);
    end_test();

    begin_test("back_pressure");
    addr = addr_t'($urandom % 16);
    data = byte_t'($urandom);
    issue_cmd({1'b1, addr, data});
    shadow[addr] = data;
    repeat (20) @(negedge clk);
    check_value("cmd_rdy while busy", 0, int'(cmd_rdy));
    issue_cmd({1'b1, addr, ~data}); // Must be ignored.
    wait_idle(IDLE_LIMIT);
    check_frame("header", {1'b1, addr});
    check_frame("data", data);
    repeat (FRAME_BITS * BAUD_DIV) @(negedge clk);
    check_value("extra frames", 0, frame_q.size());
    check_value("cmd_rdy after write", 1, int'(cmd_rdy));
    do_read(addr, MODE_NORMAL, 1);
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_cmd_seq.sv
src/uart_master.sv
verif/uart_peer.sv
verif/uart_tb.sv

/* run.sh */
#!/bin/sh
# Builds the UART master testbench with Verilator, runs it and judges the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module uart_tb -f list.f -o uart_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/uart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
